/* sources.f */
dsp_pkg.sv
hdr_extract.sv
bufid_pool.sv
descriptor_dispatch.sv
desc_fifo.sv
ingress_desc_top.sv
tb_ingress_desc.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ingress_desc -f sources.f -o sim_ingress_desc

output="$(./obj_dir/sim_ingress_desc)"
echo "$output"

if grep -qx "all tests passed" <<< "$output"; then
    exit 0
fi
exit 1

/* tb_ingress_desc.sv */
// Ingress descriptor path testbench

`timescale 1ns/1ps

module tb_ingress_desc;
    import dsp_pkg::*;

    localparam logic [1:0] ROUTE_TT  = 2'd0;
    localparam logic [1:0] ROUTE_BE  = 2'd1;
    localparam logic [1:0] ROUTE_REJ = 2'd2;
    localparam int         WAIT_MAX  = 40;

    // one row of the stimulus table
    typedef struct packed {
        frame_hdr_t hdr;
        logic       rel_wr;
        bufid_t     rel_id;
        logic [1:0] route;
        logic       drain;
    } entry_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_hdr_wr;
    frame_hdr_t  i_hdr;
    logic        i_tt_rd;
    logic        i_be_rd;
    logic        i_release_wr;
    bufid_t      i_release_bufid;
    desc_t       o_tt_desc;
    logic        o_tt_empty;
    desc_t       o_be_desc;
    logic        o_be_empty;
    drop_cnt_t   o_drop_cnt;
    logic [4:0]  o_free_cnt;

    // reference model state
    entry_t      table_q [$];
    bufid_t      free_q [$];
    bufid_t      used_q [$];
    desc_t       tt_q [$];
    desc_t       be_q [$];
    drop_cnt_t   exp_drop;
    logic [31:0] lcg_state;
    int          err_cnt;
    int          test_cnt;
    int          fail_cnt;
    bit          aborted;

    ingress_desc_top i_dut (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_hdr_wr        (i_hdr_wr),
        .i_hdr           (i_hdr),
        .i_tt_rd         (i_tt_rd),
        .i_be_rd         (i_be_rd),
        .i_release_wr    (i_release_wr),
        .i_release_bufid (i_release_bufid),
        .o_tt_desc       (o_tt_desc),
        .o_tt_empty      (o_tt_empty),
        .o_be_desc       (o_be_desc),
        .o_be_empty      (o_be_empty),
        .o_drop_cnt      (o_drop_cnt),
        .o_free_cnt      (o_free_cnt)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // expected route from the header alone
    function automatic logic [1:0] route_of(input frame_hdr_t h);
        if (h.pkt_len < 11'd64 || h.pkt_len > 11'd1522)
            return ROUTE_REJ;
        if (h.eth_type == 16'h1800 && h.frame_class <= 3'd2)
            return ROUTE_TT;
        return ROUTE_BE;
    endfunction

    task automatic check_value(input logic [39:0] got, input logic [39:0] exp,
                               input string what);
        assert (got == exp) else begin
            $display("Error %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before && !aborted) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: FAIL", test_cnt, name);
        end
    endtask

    task automatic add_row(input eth_type_t eth, input frame_class_t cls, input pkt_len_t len,
                           input logic [1:0] route, input logic drain, input int rel);
        entry_t e;
        e.hdr.eth_type    = eth;
        e.hdr.frame_class = cls;
        e.hdr.flow_id     = 14'h0a00 + 14'(table_q.size());
        e.hdr.pkt_len     = len;
        e.hdr.inport      = inport_t'(table_q.size() % 8);
        e.rel_wr          = (rel >= 0);
        e.rel_id          = (rel >= 0) ? bufid_t'(rel) : '0;
        e.route           = route;
        e.drain           = drain;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // routing by ethertype and class
        add_row(16'h1800, 3'd0, 11'd100, ROUTE_TT, 1'b1, -1);
        add_row(16'h1800, 3'd1, 11'd200, ROUTE_TT, 1'b1, -1);
        add_row(16'h1800, 3'd2, 11'd300, ROUTE_TT, 1'b1, -1);
        add_row(16'h1800, 3'd3, 11'd400, ROUTE_BE, 1'b1, -1);
        add_row(16'h1800, 3'd7, 11'd500, ROUTE_BE, 1'b1, -1);
        add_row(16'h0800, 3'd0, 11'd600, ROUTE_BE, 1'b1, -1);
        // length limits
        add_row(16'h0800, 3'd0, 11'd63, ROUTE_REJ, 1'b1, -1);
        add_row(16'h1800, 3'd0, 11'd1523, ROUTE_REJ, 1'b1, -1);
        add_row(16'h1800, 3'd1, 11'd64, ROUTE_TT, 1'b1, -1);
        add_row(16'h0800, 3'd5, 11'd1522, ROUTE_BE, 1'b1, -1);
        // tt queue fills, fifth one dropped, be keeps going
        add_row(16'h1800, 3'd0, 11'd128, ROUTE_TT, 1'b0, -1);
        add_row(16'h1800, 3'd1, 11'd256, ROUTE_TT, 1'b0, -1);
        add_row(16'h1800, 3'd2, 11'd384, ROUTE_TT, 1'b0, -1);
        add_row(16'h1800, 3'd0, 11'd512, ROUTE_TT, 1'b0, -1);
        add_row(16'h1800, 3'd1, 11'd640, ROUTE_TT, 1'b0, -1);
        add_row(16'h88f7, 3'd2, 11'd768, ROUTE_BE, 1'b0, -1);
        add_row(16'h0800, 3'd4, 11'd896, ROUTE_BE, 1'b1, -1);
        // pool runs dry, then one release
        add_row(16'h0800, 3'd1, 11'd1000, ROUTE_BE, 1'b1, -1);
        add_row(16'h0800, 3'd2, 11'd1100, ROUTE_BE, 1'b1, -1);
        add_row(16'h1800, 3'd0, 11'd1200, ROUTE_TT, 1'b1, -1);
        add_row(16'h0800, 3'd3, 11'd1300, ROUTE_BE, 1'b1, 5);
        // refill a few ids before random traffic
        add_row(16'h0800, 3'd0, 11'd63, ROUTE_REJ, 1'b1, 0);
        add_row(16'h0800, 3'd0, 11'd40, ROUTE_REJ, 1'b1, 1);
        add_row(16'h1800, 3'd0, 11'd2000, ROUTE_REJ, 1'b1, 2);
    endtask

    task automatic make_random_row(output entry_t e);
        logic [31:0] r1;
        logic [31:0] r2;
        lcg_state = lcg_next(lcg_state);
        r1        = lcg_state;
        lcg_state = lcg_next(lcg_state);
        r2        = lcg_state;
        e.hdr.eth_type    = r1[31] ? 16'h1800 : 16'h0800;
        e.hdr.frame_class = r1[30:28];
        e.hdr.flow_id     = r1[27:14];
        e.hdr.inport      = r1[13:11];
        // a few lengths fall outside 64 .. 1522
        e.hdr.pkt_len     = 11'd60 + (r2[26:16] % 11'd1470);
        e.rel_wr          = 1'b0;
        e.rel_id          = '0;
        e.route           = route_of(e.hdr);
        e.drain           = 1'b1;
    endtask

    ////////////////////////////////////////
    // queue readout
    ////////////////////////////////////////

    task automatic drain_queue(input logic tt);
        desc_t exp;
        int    wait_cyc;
        string qname;
        qname = tt ? "tt" : "be";
        while (!aborted && (tt ? tt_q.size() : be_q.size()) > 0) begin
            if (tt) begin
                exp = tt_q.pop_front();
            end else begin
                exp = be_q.pop_front();
            end
            wait_cyc = 0;
            while ((tt ? o_tt_empty : o_be_empty) && wait_cyc < WAIT_MAX) begin
                @(negedge i_clk);
                wait_cyc++;
            end
            if (tt ? o_tt_empty : o_be_empty) begin
                $display("timed out waiting for a descriptor on the %s queue", qname);
                aborted = 1'b1;
            end else begin
                check_value(tt ? o_tt_desc : o_be_desc, exp, {qname, " descriptor"});
                used_q.push_back(exp.bufid);
                i_tt_rd = tt;
                i_be_rd = !tt;
                @(negedge i_clk);
                i_tt_rd = 1'b0;
                i_be_rd = 1'b0;
            end
        end
    endtask

    ////////////////////////////////////////
    // one header through model and DUT
    ////////////////////////////////////////

    task automatic apply_row(input entry_t e);
        desc_t d;
        logic  full;
        if (e.rel_wr) begin
            free_q.push_back(e.rel_id);
        end
        if (e.route != ROUTE_REJ) begin
            full = (e.route == ROUTE_TT) ? (tt_q.size() == TT_QUEUE_DEPTH)
                                         : (be_q.size() == BE_QUEUE_DEPTH);
            // a drop takes no id
            if (full || free_q.size() == 0) begin
                exp_drop = exp_drop + 16'd1;
            end else begin
                d.bufid = free_q.pop_front();
                d.body  = '{e.hdr.frame_class, e.hdr.flow_id, e.hdr.pkt_len, e.hdr.inport};
                if (e.route == ROUTE_TT) begin
                    tt_q.push_back(d);
                end else begin
                    be_q.push_back(d);
                end
            end
        end
        i_hdr_wr        = 1'b1;
        i_hdr           = e.hdr;
        i_release_wr    = e.rel_wr;
        i_release_bufid = e.rel_id;
        @(negedge i_clk);
        i_hdr_wr     = 1'b0;
        i_release_wr = 1'b0;
        // extractor, dispatcher, queue write
        repeat (2) @(negedge i_clk);
        check_value(40'(o_drop_cnt), 40'(exp_drop), "drop counter");
        check_value(40'(o_free_cnt), 40'(free_q.size()), "free id count");
        check_value(40'(o_tt_empty), 40'(tt_q.size() == 0), "tt empty flag");
        check_value(40'(o_be_empty), 40'(be_q.size() == 0), "be empty flag");
        if (e.drain) begin
            drain_queue(1'b1);
            drain_queue(1'b0);
        end
    endtask

    initial begin
        entry_t e;
        int     errs;
        int     wait_cyc;
        i_rst_n         = 1'b0;
        i_hdr_wr        = 1'b0;
        i_hdr           = '0;
        i_tt_rd         = 1'b0;
        i_be_rd         = 1'b0;
        i_release_wr    = 1'b0;
        i_release_bufid = '0;
        exp_drop        = '0;
        lcg_state       = 32'd60;
        err_cnt         = 0;
        test_cnt        = 0;
        fail_cnt        = 0;
        aborted         = 1'b0;
        for (int i = 0; i < 16; i++) begin
            free_q.push_back(bufid_t'(i));
        end
        build_table();
        repeat (3) @(negedge i_clk);
        i_rst_n  = 1'b1;
        wait_cyc = 0;
        while (o_free_cnt != 5'd16 && wait_cyc < WAIT_MAX) begin
            @(negedge i_clk);
            wait_cyc++;
        end
        if (o_free_cnt != 5'd16) begin
            $display("buffer id pool did not fill up after reset");
            aborted = 1'b1;
        end else begin
            errs = err_cnt;
            check_value(40'(o_drop_cnt), 40'd0, "drop counter after reset");
            check_value(40'({o_tt_empty, o_be_empty}), 40'd3, "empty flags after reset");
            finish_test("reset", errs);
        end
        for (int i = 0; i < table_q.size() && !aborted; i++) begin
            errs = err_cnt;
            apply_row(table_q[i]);
            finish_test($sformatf("table row %0d", i), errs);
        end
        // random traffic recycles only its own ids
        used_q.delete();
        for (int n = 0; n < 40 && !aborted; n++) begin
            errs = err_cnt;
            make_random_row(e);
            if (used_q.size() > 0) begin
                e.rel_wr = 1'b1;
                e.rel_id = used_q.pop_front();
            end
            apply_row(e);
            finish_test($sformatf("random header %0d", n), errs);
        end
        $display("%0d tests run, %0d failing, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && !aborted) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* ingress_desc_top.sv */
// Ingress descriptor path top

`timescale 1ns/1ps

module ingress_desc_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_hdr_wr,
    input  dsp_pkg::frame_hdr_t  i_hdr,
    input  logic                 i_tt_rd,
    input  logic                 i_be_rd,
    input  logic                 i_release_wr,
    input  dsp_pkg::bufid_t      i_release_bufid,
    output dsp_pkg::desc_t       o_tt_desc,
    output logic                 o_tt_empty,
    output dsp_pkg::desc_t       o_be_desc,
    output logic                 o_be_empty,
    output dsp_pkg::drop_cnt_t   o_drop_cnt,
    output logic [4:0]           o_free_cnt
);
    import dsp_pkg::*;

    // extractor to dispatcher
    logic       desc_wr;
    desc_body_t desc_body;
    eth_type_t  eth_type;
    // pool to dispatcher
    logic       bufid_valid;
    bufid_t     bufid;
    logic       bufid_ack;
    // dispatcher to queues
    logic       tt_wr;
    desc_t      tt_desc;
    logic       tt_full;
    logic       be_wr;
    desc_t      be_desc;
    logic       be_full;

    hdr_extract u_hdr_extract (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_hdr_wr    (i_hdr_wr),
        .i_hdr       (i_hdr),
        .o_desc_wr   (desc_wr),
        .o_desc_body (desc_body),
        .o_eth_type  (eth_type)
    );

    bufid_pool u_bufid_pool (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_ack           (bufid_ack),
        .i_release_wr    (i_release_wr),
        .i_release_bufid (i_release_bufid),
        .o_bufid_valid   (bufid_valid),
        .o_bufid         (bufid),
        .o_free_cnt      (o_free_cnt)
    );

    descriptor_dispatch u_dispatch (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_desc_wr     (desc_wr),
        .i_desc_body   (desc_body),
        .i_eth_type    (eth_type),
        .i_bufid_valid (bufid_valid),
        .i_bufid       (bufid),
        .i_tt_full     (tt_full),
        .i_be_full     (be_full),
        .o_bufid_ack   (bufid_ack),
        .o_tt_wr       (tt_wr),
        .o_tt_desc     (tt_desc),
        .o_be_wr       (be_wr),
        .o_be_desc     (be_desc),
        .o_drop_cnt    (o_drop_cnt)
    );

    ////////////////////////////////////////
    // descriptor queues
    ////////////////////////////////////////

    desc_fifo #(.DEPTH(TT_QUEUE_DEPTH)) u_tt_queue (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wr    (tt_wr),
        .i_desc  (tt_desc),
        .i_rd    (i_tt_rd),
        .o_desc  (o_tt_desc),
        .o_empty (o_tt_empty),
        .o_full  (tt_full)
    );

    desc_fifo #(.DEPTH(BE_QUEUE_DEPTH)) u_be_queue (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wr    (be_wr),
        .i_desc  (be_desc),
        .i_rd    (i_be_rd),
        .o_desc  (o_be_desc),
        .o_empty (o_be_empty),
        .o_full  (be_full)
    );

endmodule

/* desc_fifo.sv */
// Show-ahead descriptor queue

`timescale 1ns/1ps

module desc_fifo #(
    parameter int DEPTH = 4
) (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_wr,
    input  dsp_pkg::desc_t  i_desc,
    input  logic            i_rd,
    output dsp_pkg::desc_t  o_desc,
    output logic            o_empty,
    output logic            o_full
);
    import dsp_pkg::*;

    desc_t                        mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;
    logic                         do_wr;
    logic                         do_rd;

    assign do_wr   = i_wr && (count != DEPTH);
    assign do_rd   = i_rd && (count != 0);
    assign o_desc  = mem[rd_ptr];
    assign o_empty = (count == 0);
    // also full when the write landing at this edge takes the last slot
    assign o_full  = (count == DEPTH) || ((count == DEPTH - 1) && i_wr && !i_rd);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) mem[wr_ptr] <= i_desc;
    end

    a_no_overrun: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_wr |-> (count != DEPTH)
    ) else $error("descriptor write into full queue");

endmodule

/* descriptor_dispatch.sv */
// Descriptor dispatcher

`timescale 1ns/1ps

module descriptor_dispatch (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_desc_wr,
    input  dsp_pkg::desc_body_t  i_desc_body,
    input  dsp_pkg::eth_type_t   i_eth_type,
    input  logic                 i_bufid_valid,
    input  dsp_pkg::bufid_t      i_bufid,
    input  logic                 i_tt_full,
    input  logic                 i_be_full,
    output logic                 o_bufid_ack,
    output logic                 o_tt_wr,
    output dsp_pkg::desc_t       o_tt_desc,
    output logic                 o_be_wr,
    output dsp_pkg::desc_t       o_be_desc,
    output dsp_pkg::drop_cnt_t   o_drop_cnt
);
    import dsp_pkg::*;

    logic  is_tt;
    logic  tgt_full;
    logic  accept;
    desc_t new_desc;

    ////////////////////////////////////////
    // classify
    ////////////////////////////////////////

    // tsn ethertype with a time-triggered class goes to the tt queue
    assign is_tt    = (i_eth_type == TSN_ETH_TYPE) && (i_desc_body.frame_class <= TT_CLASS_MAX);
    assign tgt_full = is_tt ? i_tt_full : i_be_full;
    // needs a free id and room in the chosen queue
    assign accept   = i_desc_wr && i_bufid_valid && !tgt_full;
    assign new_desc = '{bufid: i_bufid, body: i_desc_body};

    ////////////////////////////////////////
    // strobes and drop counter
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bufid_ack <= 1'b0;
            o_tt_wr     <= 1'b0;
            o_be_wr     <= 1'b0;
            o_drop_cnt  <= '0;
        end else begin
            o_bufid_ack <= accept;
            o_tt_wr     <= accept && is_tt;
            o_be_wr     <= accept && !is_tt;
            if (i_desc_wr && !accept) begin
                o_drop_cnt <= o_drop_cnt + 16'd1;
            end
        end
    end

    // descriptors held until the next write into the same queue
    always_ff @(posedge i_clk) begin
        if (accept && is_tt) begin
            o_tt_desc <= new_desc;
        end
        if (accept && !is_tt) begin
            o_be_desc <= new_desc;
        end
    end

    a_one_queue: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_tt_wr && o_be_wr)
    ) else $error("descriptor written to both queues");

endmodule

/* bufid_pool.sv */
// Packet buffer id pool

`timescale 1ns/1ps

module bufid_pool (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_ack,
    input  logic             i_release_wr,
    input  dsp_pkg::bufid_t  i_release_bufid,
    output logic             o_bufid_valid,
    output dsp_pkg::bufid_t  o_bufid,
    output logic [4:0]       o_free_cnt
);
    import dsp_pkg::*;

    typedef enum logic {
        FILL,
        RUN
    } pool_state_t;

    pool_state_t                  state;
    bufid_t                       free_list [BUFID_NUM];
    logic [$clog2(BUFID_NUM)-1:0] rd_ptr;
    logic [$clog2(BUFID_NUM)-1:0] wr_ptr;
    logic [$clog2(BUFID_NUM)-1:0] rd_ptr_nxt;
    logic [$clog2(BUFID_NUM)-1:0] wr_ptr_nxt;
    logic [4:0]                   free_cnt;
    logic                         fill_wr;
    logic                         push;
    logic                         pop;

    assign rd_ptr_nxt = (rd_ptr == BUFID_NUM - 1) ? '0 : rd_ptr + 1'b1;
    assign wr_ptr_nxt = (wr_ptr == BUFID_NUM - 1) ? '0 : wr_ptr + 1'b1;

    // fill writes the slot index as the id, so ids come out ascending
    assign fill_wr = (state == FILL);
    assign push    = (state == RUN) && i_release_wr && (free_cnt != BUFID_NUM);
    assign pop     = (state == RUN) && i_ack && (free_cnt != 5'd0);

    // head as it stands once the pending ack has popped
    assign o_bufid_valid = (state == RUN) && (i_ack ? (free_cnt > 5'd1) : (free_cnt != 5'd0));
    assign o_bufid       = i_ack ? free_list[rd_ptr_nxt] : free_list[rd_ptr];
    assign o_free_cnt    = free_cnt;

    ////////////////////////////////////////
    // init fsm, pointers and count
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= FILL;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            free_cnt <= '0;
        end else begin
            case (state)
                FILL:    if (wr_ptr == BUFID_NUM - 1) state <= RUN;
                RUN:     state <= RUN;
                default: state <= FILL;
            endcase
            if (fill_wr || push) wr_ptr <= wr_ptr_nxt;
            if (pop) rd_ptr <= rd_ptr_nxt;
            free_cnt <= free_cnt + {4'd0, fill_wr || push} - {4'd0, pop};
        end
    end

    always_ff @(posedge i_clk) begin
        if (fill_wr || push) begin
            free_list[wr_ptr] <= fill_wr ? bufid_t'(wr_ptr) : i_release_bufid;
        end
    end

    // the dispatcher only acks a head it saw as valid
    a_ack_nonempty: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_ack |-> (state == RUN) && (free_cnt != 5'd0)
    ) else $error("buffer id ack while pool empty");

    a_release_room: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_release_wr |-> (free_cnt != BUFID_NUM)
    ) else $error("buffer id release into full pool");

endmodule

/* hdr_extract.sv */
// Frame header extractor

`timescale 1ns/1ps

module hdr_extract (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_hdr_wr,
    input  dsp_pkg::frame_hdr_t  i_hdr,
    output logic                 o_desc_wr,
    output dsp_pkg::desc_body_t  o_desc_body,
    output dsp_pkg::eth_type_t   o_eth_type
);
    import dsp_pkg::*;

    logic len_ok;
    logic accept;

    // runt and oversized frames never leave this block
    assign len_ok = (i_hdr.pkt_len >= MIN_FRAME_LEN) && (i_hdr.pkt_len <= MAX_FRAME_LEN);
    assign accept = i_hdr_wr && len_ok;

    ////////////////////////////////////////
    // strobe
    ////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_desc_wr <= 1'b0;
        end else begin
            o_desc_wr <= accept;
        end
    end

    ////////////////////////////////////////
    // descriptor body
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_desc_body <= '{frame_class: i_hdr.frame_class,
                             flow_id:     i_hdr.flow_id,
                             pkt_len:     i_hdr.pkt_len,
                             inport:      i_hdr.inport};
            o_eth_type  <= i_hdr.eth_type;
        end
    end

    // a two-cycle strobe needs a header in each of the two cycles before
    a_strobe_source: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_desc_wr && $past(o_desc_wr)) |-> ($past(i_hdr_wr, 2) && $past(i_hdr_wr))
    ) else $error("descriptor strobe held without matching header strobes");

endmodule

/* dsp_pkg.sv */
// Ingress descriptor definitions

package dsp_pkg;

    ////////////////////////////////////////
    // field widths
    ////////////////////////////////////////

    typedef logic [8:0]  bufid_t;
    typedef logic [15:0] eth_type_t;
    // classes 0 to 2 are time-triggered
    typedef logic [2:0]  frame_class_t;
    typedef logic [13:0] flow_id_t;
    typedef logic [10:0] pkt_len_t;
    typedef logic [2:0]  inport_t;
    typedef logic [15:0] drop_cnt_t;

    ////////////////////////////////////////
    // limits
    ////////////////////////////////////////

    localparam eth_type_t    TSN_ETH_TYPE   = 16'h1800;
    localparam frame_class_t TT_CLASS_MAX   = 3'd2;
    localparam pkt_len_t     MIN_FRAME_LEN  = 11'd64;
    localparam pkt_len_t     MAX_FRAME_LEN  = 11'd1522;
    // pool owns ids 0 .. BUFID_NUM-1
    localparam int           BUFID_NUM      = 16;
    localparam int           TT_QUEUE_DEPTH = 4;
    localparam int           BE_QUEUE_DEPTH = 8;

    ////////////////////////////////////////
    // header and descriptor layouts
    ////////////////////////////////////////

    // parsed header, one per strobe
    typedef struct packed {
        eth_type_t    eth_type;
        frame_class_t frame_class;
        flow_id_t     flow_id;
        pkt_len_t     pkt_len;
        inport_t      inport;
    } frame_hdr_t;

    // descriptor bits 30:0
    typedef struct packed {
        frame_class_t frame_class;
        flow_id_t     flow_id;
        pkt_len_t     pkt_len;
        inport_t      inport;
    } desc_body_t;

    // buffer id in bits 39:31
    typedef struct packed {
        bufid_t     bufid;
        desc_body_t body;
    } desc_t;

endpackage
